// ==== source/dct_pkg.sv ====
//***********************************************************
// shared widths, rounding positions and cosine table of the dct
// constants are unsigned, lane sign lives in the table msb
//***********************************************************
`default_nettype none

package dct_pkg;

  localparam int PIXEL_W    = 10;  // signed input sample
  localparam int TM_W       = 16;  // transpose memory word
  localparam int COEF_OUT_W = 13;  // final coefficient

  localparam int BLOCK_SIZE = 64;
  localparam int ROW_LEN    = 8;
  localparam int LANES      = ROW_LEN / 2;  // butterfly pairs
  localparam int CNT_W      = $clog2(BLOCK_SIZE);
  localparam int IDX_W      = $clog2(ROW_LEN);
  localparam int TM_ADDR_W  = 7;  // {page, row, k}

  // row pass keeps product [26:9], sum [18:3]
  localparam int ROW_PROD_LSB  = 9;
  localparam int ROW_ROUND_LSB = 3;
  // column pass keeps product [32:14], sum [20:8]
  localparam int COL_PROD_LSB  = 14;
  localparam int COL_ROUND_LSB = 8;

  localparam int ENGINE_LATENCY = 6;   // load to first k
  localparam int DCT_LATENCY    = 91;  // i_start to first o_dv

  localparam int CONST_W = 16;
  localparam int LANE_W  = CONST_W + 1;  // sign + magnitude

  // cos(n*pi/16) scaled, see table below for use per k
  localparam logic [CONST_W-1:0] C3 = 16'd54491;
  localparam logic [CONST_W-1:0] S3 = 16'd36410;
  localparam logic [CONST_W-1:0] C4 = 16'd46341;
  localparam logic [CONST_W-1:0] C6 = 16'd25080;
  localparam logic [CONST_W-1:0] S6 = 16'd60547;
  localparam logic [CONST_W-1:0] C7 = 16'd12785;
  localparam logic [CONST_W-1:0] S7 = 16'd64277;

  // row k, lane j; msb set means negative constant
  localparam logic [0:ROW_LEN-1][0:LANES-1][LANE_W-1:0] COEF_TABLE = {
    {{1'b0, C4}, {1'b0, C4}, {1'b0, C4}, {1'b0, C4}},  // k0
    {{1'b0, S7}, {1'b0, C3}, {1'b0, S3}, {1'b0, C7}},  // k1
    {{1'b0, S6}, {1'b0, C6}, {1'b1, C6}, {1'b1, S6}},  // k2
    {{1'b0, C3}, {1'b1, C7}, {1'b1, S7}, {1'b1, S3}},  // k3
    {{1'b0, C4}, {1'b1, C4}, {1'b1, C4}, {1'b0, C4}},  // k4
    {{1'b0, S3}, {1'b1, S7}, {1'b0, C7}, {1'b0, C3}},  // k5
    {{1'b0, C6}, {1'b1, S6}, {1'b0, S6}, {1'b1, C6}},  // k6
    {{1'b0, C7}, {1'b1, S3}, {1'b0, C3}, {1'b1, S7}}   // k7
  };

  typedef logic signed [PIXEL_W-1:0]    pixel_t;
  typedef logic signed [TM_W-1:0]       tm_word_t;
  typedef logic signed [COEF_OUT_W-1:0] dct_coef_t;

  // transpose memory write port bundle
  typedef struct packed {
    logic                 en;
    logic [TM_ADDR_W-1:0] addr;
    tm_word_t             data;
  } tm_write_t;

  // output stream bundle
  typedef struct packed {
    logic      valid;
    dct_coef_t coef;
  } dct_out_t;

endpackage

`default_nettype wire

// ==== source/row_dct_engine.sv ====
//***********************************************************
// 8-point 1-d dct datapath, coefficient k = 0..7 one per cycle
// loads at least 8 cycles apart, first k 6 cycles after load
//***********************************************************
`default_nettype none

module row_dct_engine #(
  parameter type sample_t  = dct_pkg::pixel_t,
  parameter int  PROD_LSB  = dct_pkg::ROW_PROD_LSB,
  parameter int  ROUND_LSB = dct_pkg::ROW_ROUND_LSB,
  parameter int  OUT_W     = dct_pkg::TM_W
) (
  input  wire logic             clk,
  input  wire sample_t          i_sample,
  input  wire logic             i_load,    // 8th sample on i_sample
  output logic                  o_valid,
  output logic [OUT_W-1:0]      o_coef
);
  import dct_pkg::*;

  localparam int SW    = $bits(sample_t);
  localparam int BW    = SW + 1;              // butterfly sum
  localparam int PW    = SW + CONST_W + 1;    // product, top bit always 0
  localparam int KW    = PW - PROD_LSB;       // kept product slice
  localparam int SUM_W = ROUND_LSB + OUT_W;   // final sum, wraps like the original
  localparam int VL_W  = ROW_LEN + ENGINE_LATENCY - 1;

  sample_t                 sr [ROW_LEN-1];  // previous 7 samples, [0] newest
  sample_t                 x  [ROW_LEN];    // captured row, [0] oldest
  logic [IDX_W-1:0]        idx;             // k of the butterfly stage
  logic [IDX_W-1:0]        idx_d;           // k of the table lookup
  logic signed [BW-1:0]    bf     [LANES];
  logic [BW-1:0]           bf_abs [LANES];
  logic [SW-1:0]           mag    [LANES];
  logic                    sgn    [LANES];
  logic [LANE_W-1:0]       lane_c [LANES];
  logic [PW-1:0]           prod   [LANES];
  logic [KW-1:0]           pk     [LANES];
  logic signed [KW-1:0]    p      [LANES];
  logic signed [KW:0]      pair0;
  logic signed [KW:0]      pair1;
  logic signed [SUM_W-1:0] sum;
  logic [VL_W-1:0]         ld_sr;           // load history for valid

  // sample window, shifts every cycle
  always_ff @(posedge clk) begin
    sr[0] <= i_sample;
    for (int m = 1; m < ROW_LEN - 1; m++) begin
      sr[m] <= sr[m-1];
    end
    if (i_load) begin  // window + current input = whole row
      for (int j = 0; j < ROW_LEN - 1; j++) begin
        x[j] <= sr[ROW_LEN-2-j];
      end
      x[ROW_LEN-1] <= i_sample;
    end
  end

  // k counter restarts on every load, free running otherwise
  always_ff @(posedge clk) begin
    if (i_load) idx <= '0;
    else        idx <= idx + 1'b1;
    idx_d <= idx;
  end

  // butterfly, sum for even k and difference for odd k
  always_ff @(posedge clk) begin
    for (int j = 0; j < LANES; j++) begin
      if (!idx[0]) bf[j] <= x[j] + x[ROW_LEN-1-j];
      else         bf[j] <= x[j] - x[ROW_LEN-1-j];
    end
  end

  always_comb begin
    for (int j = 0; j < LANES; j++) begin
      bf_abs[j] = bf[j][BW-1] ? -bf[j] : bf[j];
    end
  end

  // magnitude and sign, table row fetched alongside
  always_ff @(posedge clk) begin
    for (int j = 0; j < LANES; j++) begin
      sgn[j]    <= bf[j][BW-1];
      mag[j]    <= bf_abs[j][SW-1:0];  // msb dropped as in the original
      lane_c[j] <= COEF_TABLE[idx_d][j];
    end
  end

  // unsigned multiply, slice, then restore sign
  always_comb begin
    for (int j = 0; j < LANES; j++) begin
      prod[j] = PW'(mag[j]) * PW'(lane_c[j][CONST_W-1:0]);
      pk[j]   = prod[j][PW-1:PROD_LSB];
    end
  end

  always_ff @(posedge clk) begin
    for (int j = 0; j < LANES; j++) begin
      p[j] <= (sgn[j] ^ lane_c[j][CONST_W]) ? -pk[j] : pk[j];
    end
  end

  // adder tree, first level registered
  always_ff @(posedge clk) begin
    pair0 <= p[0] + p[1];
    pair1 <= p[2] + p[3];
  end

  assign sum = pair0 + pair1;  // second level feeds the round register

  always_ff @(posedge clk) begin
    o_coef <= sum[SUM_W-1:ROUND_LSB] + {{(OUT_W-1){1'b0}}, sum[ROUND_LSB-1]};
  end

  // one load gives 8 valid cycles starting at load + latency
  always_ff @(posedge clk) begin
    ld_sr <= {ld_sr[VL_W-2:0], i_load};
  end

  assign o_valid = |ld_sr[VL_W-1:ENGINE_LATENCY-1];

endmodule

`default_nettype wire

// ==== source/dct_row_stage.sv ====
//***********************************************************
// row pass, next i_start no earlier than 64 cycles after the last
// writes row r, k to {page, r, k}, page flips per block
//***********************************************************
`default_nettype none

module dct_row_stage (
  input  wire logic               clk,
  input  wire logic               i_rst_n,
  input  wire logic               i_start,    // with sample 0
  input  wire dct_pkg::pixel_t    i_sample,
  output dct_pkg::tm_write_t      o_wr,
  output logic                    o_page_done, // last write of a block
  output logic                    o_done_page  // page just filled, valid with done
);
  import dct_pkg::*;

  logic             in_active;
  logic [CNT_W-1:0] in_cnt;     // index of the sample on i_sample
  logic             row_end;
  logic             eng_valid;
  logic [TM_W-1:0]  eng_coef;
  logic [CNT_W-1:0] wr_cnt;     // 8*row + k
  logic             page;

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      in_active <= 1'b0;
      in_cnt    <= '0;
    end else if (i_start) begin
      in_active <= 1'b1;
      in_cnt    <= CNT_W'(1);  // sample 0 is the start cycle itself
    end else if (in_active) begin
      in_cnt <= in_cnt + 1'b1;
      if (in_cnt == CNT_W'(BLOCK_SIZE - 1)) in_active <= 1'b0;
    end
  end

  assign row_end = in_active && (in_cnt[IDX_W-1:0] == IDX_W'(ROW_LEN - 1));

  row_dct_engine #(
    .sample_t  (pixel_t),
    .PROD_LSB  (ROW_PROD_LSB),
    .ROUND_LSB (ROW_ROUND_LSB),
    .OUT_W     (TM_W)
  ) u_engine (
    .clk      (clk),
    .i_sample (i_sample),
    .i_load   (row_end),
    .o_valid  (eng_valid),
    .o_coef   (eng_coef)
  );

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      wr_cnt <= '0;
      page   <= 1'b0;
    end else if (eng_valid) begin
      wr_cnt <= wr_cnt + 1'b1;
      if (wr_cnt == CNT_W'(BLOCK_SIZE - 1)) page <= ~page;  // 64th write
    end
  end

  always_comb begin
    o_wr.en   = eng_valid;
    o_wr.addr = {page, wr_cnt};  // row in [5:3], k in [2:0]
    o_wr.data = tm_word_t'(eng_coef);
  end

  assign o_page_done = eng_valid && (wr_cnt == CNT_W'(BLOCK_SIZE - 1));
  assign o_done_page = page;

endmodule

`default_nettype wire

// ==== source/dct_column_stage.sv ====
//***********************************************************
// column pass, reads a full page column by column
// output u-major, o_pre_first one cycle before coefficient 0
//***********************************************************
`default_nettype none

module dct_column_stage (
  input  wire logic                        clk,
  input  wire logic                        i_rst_n,
  input  wire logic                        i_page_done,
  input  wire logic                        i_done_page,
  output logic [dct_pkg::TM_ADDR_W-1:0]    o_rd_addr,
  input  wire dct_pkg::tm_word_t           i_rd_data,   // one cycle after address
  output dct_pkg::dct_out_t                o_out,
  output logic                             o_pre_first
);
  import dct_pkg::*;

  logic                      rd_active;
  logic                      rd_page;
  logic [CNT_W-1:0]          rd_cnt;    // [2:0] row, [5:3] column k
  logic                      col_end;
  logic                      load_q;    // col_end aligned to read data
  logic                      first_q;   // load of column 0
  logic [ENGINE_LATENCY-2:0] pf_sr;
  logic                      eng_valid;
  logic [COEF_OUT_W-1:0]     eng_coef;
  logic                      dv_q;
  logic [CNT_W-1:0]          out_cnt;

  // read scan, a new page restarts it even on the last count
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      rd_active <= 1'b0;
      rd_page   <= 1'b0;
      rd_cnt    <= '0;
    end else if (i_page_done) begin
      rd_active <= 1'b1;
      rd_page   <= i_done_page;
      rd_cnt    <= '0;
    end else if (rd_active) begin
      rd_cnt <= rd_cnt + 1'b1;
      if (rd_cnt == CNT_W'(BLOCK_SIZE - 1)) rd_active <= 1'b0;
    end
  end

  assign o_rd_addr = {rd_page, rd_cnt[IDX_W-1:0], rd_cnt[CNT_W-1:IDX_W]};  // transposed
  assign col_end   = rd_active && (rd_cnt[IDX_W-1:0] == IDX_W'(ROW_LEN - 1));

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      load_q  <= 1'b0;
      first_q <= 1'b0;
      pf_sr   <= '0;
      dv_q    <= 1'b0;
      out_cnt <= '0;
    end else begin
      load_q  <= col_end;
      first_q <= col_end && (rd_cnt[CNT_W-1:IDX_W] == '0);
      pf_sr   <= {pf_sr[ENGINE_LATENCY-3:0], first_q};
      // 64-cycle output window, back to back blocks chain
      if (o_pre_first) begin
        dv_q    <= 1'b1;
        out_cnt <= '0;
      end else if (dv_q) begin
        out_cnt <= out_cnt + 1'b1;
        if (out_cnt == CNT_W'(BLOCK_SIZE - 1)) dv_q <= 1'b0;
      end
    end
  end

  assign o_pre_first = pf_sr[ENGINE_LATENCY-2];

  row_dct_engine #(
    .sample_t  (tm_word_t),
    .PROD_LSB  (COL_PROD_LSB),
    .ROUND_LSB (COL_ROUND_LSB),
    .OUT_W     (COEF_OUT_W)
  ) u_engine (
    .clk      (clk),
    .i_sample (i_rd_data),
    .i_load   (load_q),
    .o_valid  (eng_valid),
    .o_coef   (eng_coef)
  );

  // engine valid, limited to the live block window
  always_comb begin
    o_out.valid = dv_q & eng_valid;
    o_out.coef  = dct_coef_t'(eng_coef);
  end

endmodule

`default_nettype wire

// ==== source/transpose_ram.sv ====
//***********************************************************
// 128 x 16 two-port memory, registered read, no read-through
//***********************************************************
`default_nettype none

module transpose_ram (
  input  wire logic                        clk,
  input  wire dct_pkg::tm_write_t          i_wr,
  input  wire logic [dct_pkg::TM_ADDR_W-1:0] i_rd_addr,
  output dct_pkg::tm_word_t                o_rd_data
);
  import dct_pkg::*;

  tm_word_t mem [2**TM_ADDR_W];  // two pages of 64 words

  always_ff @(posedge clk) begin
    if (i_wr.en) begin
      mem[i_wr.addr] <= i_wr.data;
    end
    o_rd_data <= mem[i_rd_addr];  // old data on same-address collision
  end

endmodule

`default_nettype wire

// ==== source/dct_8x8.sv ====
//***********************************************************
// 8x8 2-d dct, fixed-rate stream, no back-pressure
// first o_dv 91 cycles after i_start, 64 coefficients u-major
//***********************************************************
`default_nettype none

module dct_8x8 (
  input  wire logic               clk,
  input  wire logic               i_rst_n,
  input  wire logic               i_start,   // one cycle, with sample 0
  input  wire dct_pkg::pixel_t    i_sample,  // row-major
  output dct_pkg::dct_coef_t      o_coef,
  output logic                    o_dv,
  output logic                    o_pre_first
);
  import dct_pkg::*;

  tm_write_t              tm_wr;
  logic                   page_done;
  logic                   done_page;
  logic [TM_ADDR_W-1:0]   tm_rd_addr;
  tm_word_t               tm_rd_data;
  dct_out_t               col_out;

  // rows in, transposed words to memory
  dct_row_stage u_row (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_start     (i_start),
    .i_sample    (i_sample),
    .o_wr        (tm_wr),
    .o_page_done (page_done),
    .o_done_page (done_page)
  );

  transpose_ram u_tm (
    .clk       (clk),
    .i_wr      (tm_wr),
    .i_rd_addr (tm_rd_addr),
    .o_rd_data (tm_rd_data)
  );

  // columns out of the filled page
  dct_column_stage u_col (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_page_done (page_done),
    .i_done_page (done_page),
    .o_rd_addr   (tm_rd_addr),
    .i_rd_data   (tm_rd_data),
    .o_out       (col_out),
    .o_pre_first (o_pre_first)
  );

  assign o_coef = col_out.coef;
  assign o_dv   = col_out.valid;

endmodule

`default_nettype wire

// ==== testbench/dct_checker.sv ====
//***********************************************************
// reference model of the fixed-point 2-d dct, output compare
// blocks in flight are dropped when i_rst_n goes low
//***********************************************************
`default_nettype none

module dct_checker (
  input  wire logic               clk,
  input  wire logic               i_rst_n,
  input  wire logic               i_start,
  input  wire dct_pkg::pixel_t    i_sample,
  input  wire dct_pkg::dct_coef_t i_coef,
  input  wire logic               i_dv,
  input  wire logic               i_pre_first,
  input  wire logic [3:0]         i_test_id,
  input  wire logic               i_test_end,   // one cycle, prints the test line
  output logic                    o_idle,       // nothing captured or pending
  output int                      o_err_count,
  output int                      o_coef_count,
  output int                      o_block_count
);
  import dct_pkg::*;

  longint cap [BLOCK_SIZE];   // samples of the block being captured
  longint rowc [ROW_LEN][ROW_LEN];
  longint xs [ROW_LEN];
  longint exp_q [$];          // expected coefficients, u-major
  longint start_q [$];        // i_start cycle per block
  bit     const_q [$];        // block had one value only
  longint cycle      = 0;
  longint got;
  longint want;
  int     cap_idx    = 0;
  bit     capturing  = 0;
  bit     same_val;
  int     out_idx    = 0;
  bit     pf_d       = 0;     // o_pre_first one cycle back
  int     run_len    = 0;
  int     max_run    = 0;
  int     errs       = 0;
  int     test_errs  = 0;
  int     test_coefs = 0;
  int     coefs      = 0;
  int     blocks     = 0;

  // counts for the run and for the current test
  function automatic void note_error();
    errs++;
    test_errs++;
  endfunction

  // lane constant with sign bit on top, from the cosine table
  function automatic logic [16:0] lane_const(input int k, input int j);
    logic [16:0] lanes [4];
    case (k)
      0: lanes = '{{1'b0, C4}, {1'b0, C4}, {1'b0, C4}, {1'b0, C4}};
      1: lanes = '{{1'b0, S7}, {1'b0, C3}, {1'b0, S3}, {1'b0, C7}};
      2: lanes = '{{1'b0, S6}, {1'b0, C6}, {1'b1, C6}, {1'b1, S6}};
      3: lanes = '{{1'b0, C3}, {1'b1, C7}, {1'b1, S7}, {1'b1, S3}};
      4: lanes = '{{1'b0, C4}, {1'b1, C4}, {1'b1, C4}, {1'b0, C4}};
      5: lanes = '{{1'b0, S3}, {1'b1, S7}, {1'b0, C7}, {1'b0, C3}};
      6: lanes = '{{1'b0, C6}, {1'b1, S6}, {1'b0, S6}, {1'b1, C6}};
      default: lanes = '{{1'b0, C7}, {1'b1, S3}, {1'b0, C3}, {1'b1, S7}};
    endcase
    return lanes[j];
  endfunction

  // one 8-point coefficient, butterfly / magnitude / slice / round
  function automatic longint dct_point(input longint v [ROW_LEN], input int k,
                                       input int sw, input int prod_lsb,
                                       input int round_lsb, input int out_w);
    longint      b;
    longint      mag;
    longint      pk;
    longint      sum;
    longint      r;
    logic [16:0] lc;
    sum = 0;
    for (int j = 0; j < 4; j++) begin
      b   = (k % 2 == 0) ? v[j] + v[7-j] : v[j] - v[7-j];
      mag = (b < 0 ? -b : b) & ((longint'(1) << sw) - 1);  // top bit lost
      lc  = lane_const(k, j);
      pk  = (mag * longint'(lc[15:0])) >> prod_lsb;
      sum += ((b < 0) != lc[16]) ? -pk : pk;
    end
    r = (sum >>> round_lsb) + ((sum >>> (round_lsb - 1)) & 1);
    r = r & ((longint'(1) << out_w) - 1);  // wraps to out_w bits
    if (r[out_w-1]) r = r - (longint'(1) << out_w);
    return r;
  endfunction

  // rows first, then columns of the row results
  task automatic push_expected();
    longint col [ROW_LEN];
    for (int r = 0; r < ROW_LEN; r++) begin
      for (int c = 0; c < ROW_LEN; c++) xs[c] = cap[r*ROW_LEN+c];
      for (int u = 0; u < ROW_LEN; u++)
        rowc[r][u] = dct_point(xs, u, PIXEL_W, ROW_PROD_LSB, ROW_ROUND_LSB, TM_W);
    end
    for (int u = 0; u < ROW_LEN; u++) begin
      for (int r = 0; r < ROW_LEN; r++) col[r] = rowc[r][u];
      for (int v = 0; v < ROW_LEN; v++)
        exp_q.push_back(dct_point(col, v, TM_W, COL_PROD_LSB, COL_ROUND_LSB, COEF_OUT_W));
    end
  endtask

  function automatic string test_name(input logic [3:0] id);
    case (id)
      1: return "single random block";
      2: return "eight blocks back to back";
      3: return "blocks with random gaps";
      4: return "latency and pre-first";
      5: return "constant block";
      default: return "reset in mid block";
    endcase
  endfunction

  always @(posedge clk) begin
    cycle++;
    if (!i_rst_n) begin  // whatever was in flight is lost
      capturing = 0;
      exp_q.delete();
      start_q.delete();
      const_q.delete();
      out_idx = 0;
      run_len = 0;
      pf_d    = 0;
    end else begin
      if (i_start) begin
        if (capturing) begin
          $display("i_start came in the middle of a block at time %0t", $time);
          note_error();
        end
        capturing = 1;
        cap_idx   = 0;
        start_q.push_back(cycle);
      end
      if (capturing) begin
        cap[cap_idx] = longint'(i_sample);
        cap_idx++;
        if (cap_idx == BLOCK_SIZE) begin
          capturing = 0;
          same_val  = 1;
          for (int n = 1; n < BLOCK_SIZE; n++) begin
            if (cap[n] != cap[0]) same_val = 0;
          end
          const_q.push_back(same_val);
          push_expected();
        end
      end
      if (i_dv) begin
        run_len++;
        if (run_len > max_run) max_run = run_len;
        if (exp_q.size() == 0) begin
          $display("o_dv high with no block pending at time %0t", $time);
          note_error();
        end else begin
          if (out_idx == 0) begin  // first coefficient of a block
            if (cycle - start_q[0] != DCT_LATENCY) begin
              $display("FAIL %0t: latency %0d cycles, expected %0d", $time,
                       cycle - start_q[0], DCT_LATENCY);
              note_error();
            end
            if (!pf_d) begin
              $display("o_pre_first was not high before the first coefficient at %0t",
                       $time);
              note_error();
            end
            void'(start_q.pop_front());
          end else if (pf_d) begin
            $display("o_pre_first was high before coefficient %0d of a block at %0t",
                     out_idx, $time);
            note_error();
          end
          got  = longint'(i_coef);
          want = exp_q.pop_front();
          if (got != want) begin
            $display("FAIL %0t: block %0d u=%0d v=%0d got %0d expected %0d", $time,
                     blocks, out_idx / 8, out_idx % 8, got, want);
            note_error();
          end
          if (const_q[0] && out_idx != 0 && got != 0) begin
            $display("FAIL %0t: constant block u=%0d v=%0d is %0d, expected 0", $time,
                     out_idx / 8, out_idx % 8, got);
            note_error();
          end
          coefs++;
          test_coefs++;
          out_idx++;
          if (out_idx == BLOCK_SIZE) begin
            out_idx = 0;
            blocks++;
            void'(const_q.pop_front());
          end
        end
      end else begin
        run_len = 0;
      end
      pf_d = i_pre_first;
    end
    if (i_test_end) begin
      if (i_test_id == 4'd2 && max_run < 8 * BLOCK_SIZE) begin
        $display("o_dv dropped between back to back blocks, longest run %0d", max_run);
        note_error();
      end
      $display("test %0d %s: %0d coefficients, %0d errors, %s", i_test_id,
               test_name(i_test_id), test_coefs, test_errs, test_errs == 0 ? "ok" : "bad");
      test_errs  = 0;
      test_coefs = 0;
      max_run    = 0;
    end
    o_idle        <= !capturing && exp_q.size() == 0;
    o_err_count   <= errs;
    o_coef_count  <= coefs;
    o_block_count <= blocks;
  end

endmodule

`default_nettype wire

// ==== testbench/dct_props.sv ====
//***********************************************************
// output timing and write burst assertions, bound into dct_8x8
//***********************************************************
`default_nettype none

module dct_props (
  input wire logic               clk,
  input wire logic               i_rst_n,
  input wire logic               i_dv,
  input wire logic               i_pre_first,
  input wire dct_pkg::tm_write_t i_wr
);
  import dct_pkg::*;

  int burst_len;  // cycles of the current write burst

  always_ff @(posedge clk) begin
    if (!i_rst_n)     burst_len <= 0;
    else if (i_wr.en) burst_len <= burst_len + 1;
    else              burst_len <= 0;
  end

  // coefficient 0 follows pre-first directly
  a_pre_first: assert property (@(posedge clk) disable iff (!i_rst_n)
    i_pre_first |=> i_dv)
    else $error("o_pre_first not followed by o_dv");

  a_reset_quiet: assert property (@(posedge clk)
    (!i_rst_n && !$past(i_rst_n)) |-> !i_dv)
    else $error("o_dv high during reset");

  // rows of 8 words, chained rows give multiples of 8
  a_wr_burst: assert property (@(posedge clk) disable iff (!i_rst_n)
    (!i_wr.en && burst_len != 0) |-> (burst_len % ROW_LEN == 0))
    else $error("write burst not a multiple of 8 cycles");

endmodule

bind dct_8x8 dct_props u_props (
  .clk         (clk),
  .i_rst_n     (i_rst_n),
  .i_dv        (o_dv),
  .i_pre_first (o_pre_first),
  .i_wr        (tm_wr)
);

`default_nettype wire

// ==== testbench/dct_8x8_tb.sv ====
//***********************************************************
// random blocks from seed 22, samples limited to -255..255
// watchdog sized from block count and gaps
//***********************************************************
`default_nettype none

module dct_8x8_tb;
  import dct_pkg::*;

  localparam int TOTAL_BLOCKS = 1 + 8 + 6 + 1 + 2 + 3;
  localparam int GAP_CYCLES   = 6 * 40 + 6 * (DCT_LATENCY + 20) + 2 * 16;
  localparam longint WATCHDOG_TIME =
    longint'(TOTAL_BLOCKS * 64 + GAP_CYCLES + 2 * DCT_LATENCY + 100) * 8;

  logic       clk;
  logic       i_rst_n;
  logic       i_start;
  pixel_t     i_sample;
  dct_coef_t  o_coef;
  logic       o_dv;
  logic       o_pre_first;
  logic [3:0] test_id;
  logic       test_end;
  logic       chk_idle;
  int         err_count;
  int         coef_count;
  int         block_count;

  dct_8x8 u_dut (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_start     (i_start),
    .i_sample    (i_sample),
    .o_coef      (o_coef),
    .o_dv        (o_dv),
    .o_pre_first (o_pre_first)
  );

  dct_checker u_chk (
    .clk           (clk),
    .i_rst_n       (i_rst_n),
    .i_start       (i_start),
    .i_sample      (i_sample),
    .i_coef        (o_coef),
    .i_dv          (o_dv),
    .i_pre_first   (o_pre_first),
    .i_test_id     (test_id),
    .i_test_end    (test_end),
    .o_idle        (chk_idle),
    .o_err_count   (err_count),
    .o_coef_count  (coef_count),
    .o_block_count (block_count)
  );

  always #4 clk = ~clk;  // period 8

  function automatic pixel_t rand_pixel();
    int v;
    v = int'($urandom % 511) - 255;
    return pixel_t'(v);
  endfunction

  // 64 samples on consecutive cycles, start with the first
  task automatic send_block(input bit flat, input int n_samples);
    pixel_t level;
    level = rand_pixel();
    for (int i = 0; i < n_samples; i++) begin
      @(posedge clk);
      i_start  <= (i == 0);
      i_sample <= flat ? level : rand_pixel();
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      i_start  <= 1'b0;
      i_sample <= '0;
    end
  endtask

  // wait for the checker to drain, then close the test
  task automatic finish_test(input logic [3:0] id);
    idle_cycles(2);
    while (!chk_idle) @(posedge clk);
    @(posedge clk);
    test_id  <= id;
    test_end <= 1'b1;
    @(posedge clk);
    test_end <= 1'b0;
    @(posedge clk);
  endtask

  task automatic apply_reset();
    @(posedge clk);
    i_rst_n <= 1'b0;
    i_start <= 1'b0;
    repeat (16) @(posedge clk);
    i_rst_n <= 1'b1;
  endtask

  initial begin
    void'($urandom(22));
    clk      = 1'b0;
    i_rst_n  = 1'b0;
    i_start  = 1'b0;
    i_sample = '0;
    test_id  = '0;
    test_end = 1'b0;
    repeat (16) @(posedge clk);
    i_rst_n <= 1'b1;
    idle_cycles(4);

    send_block(1'b0, 64);  // single block
    finish_test(4'd1);

    for (int b = 0; b < 8; b++) send_block(1'b0, 64);  // no gaps
    finish_test(4'd2);

    for (int b = 0; b < 6; b++) begin
      send_block(1'b0, 64);
      idle_cycles(int'($urandom % 41));
    end
    finish_test(4'd3);

    send_block(1'b0, 64);  // into an empty pipeline, latency also checked on all others
    finish_test(4'd4);

    send_block(1'b1, 64);
    idle_cycles(10);
    send_block(1'b1, 64);
    finish_test(4'd5);

    send_block(1'b0, 64);  // still streaming out when reset hits
    send_block(1'b0, 30);  // cut short by reset
    apply_reset();
    idle_cycles(3);
    send_block(1'b0, 64);
    finish_test(4'd6);

    $display("summary: 6 tests, %0d blocks, %0d coefficients, %0d errors",
             block_count, coef_count, err_count);
    if (err_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_TIME);
    $display("watchdog expired, the run did not finish in %0d time units", WATCHDOG_TIME);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== dct_8x8.f ====
source/dct_pkg.sv
source/row_dct_engine.sv
source/dct_row_stage.sv
source/dct_column_stage.sv
source/transpose_ram.sv
source/dct_8x8.sv
testbench/dct_checker.sv
testbench/dct_props.sv
testbench/dct_8x8_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the dct_8x8 testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module dct_8x8_tb \
  -f dct_8x8.f \
  -o sim_dct_8x8

./obj_dir/sim_dct_8x8 | tee sim.log || true

if grep -qx "TEST OK" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
